// File: dv/tb_frame_writer.sv
module tb_frame_writer;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 dclk;
    logic                 rst_n;
    logic                 en;
    vram_pkg::byte_t      data8b;
    logic                 rd_en;
    vram_pkg::vram_addr_t rd_addr;
    logic                 rd_valid;
    vram_pkg::pixel_t     rd_pixel;

    // reference planes, colour then address
    vram_pkg::byte_t model [vram_pkg::num_planes][vram_pkg::pix_count];
    int test_errors;
    int tests_passed;
    int tests_failed;

    frame_writer_top dut_i (
        .dclk     (dclk),
        .rst_n    (rst_n),
        .en       (en),
        .data8b   (data8b),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel)
    );

    initial begin
        dclk = 1'b0;
        forever #4 dclk = ~dclk;
    end

    // out of range start goes to pixel 0
    function automatic vram_pkg::vram_addr_t first_addr(input logic [23:0] start);
        if (int'(start) < vram_pkg::pix_count)
            return start[vram_pkg::addr_w-1:0];
        return '0;
    endfunction

    // wrap after the last pixel of the frame
    function automatic vram_pkg::vram_addr_t next_addr(input vram_pkg::vram_addr_t a);
        if (a == vram_pkg::vram_addr_t'(vram_pkg::pix_count - 1))
            return '0;
        return a + 1'b1;
    endfunction

    function automatic vram_pkg::pixel_t expected_pixel(input vram_pkg::vram_addr_t a);
        vram_pkg::pixel_t px;
        px.red   = model[vram_pkg::color_red][a];
        px.green = model[vram_pkg::color_green][a];
        px.blue  = model[vram_pkg::color_blue][a];
        return px;
    endfunction

    task automatic check_pixel(input string name, input vram_pkg::pixel_t exp,
                               input vram_pkg::pixel_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected pixel %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_byte(input string name, input vram_pkg::byte_t exp,
                              input vram_pkg::byte_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected byte %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected rd_valid %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    // one byte per cycle, 1 ns after the edge
    task automatic drive_byte(input vram_pkg::byte_t b, input logic e);
        en     = e;
        data8b = b;
        @(posedge dclk);
        #1;
    endtask

    task automatic drive_bytes(input vram_pkg::byte_t q[$], input logic e);
        foreach (q[i])
            drive_byte(q[i], e);
    endtask

    // en low long enough for the last write to land
    task automatic idle(input int n);
        en     = 1'b0;
        data8b = '0;
        repeat (n) begin
            @(posedge dclk);
            #1;
        end
    endtask

    // sync, start address, then rgb bytes; keep cuts the stream early
    task automatic send_packet(input logic [23:0] start, input vram_pkg::byte_t data[$],
                               input int keep = -1);
        vram_pkg::vram_addr_t addr;
        logic [1:0]           color;
        int                   n;
        n     = (keep < 0) ? data.size() : keep;
        addr  = first_addr(start);
        color = 2'd0;
        drive_byte(vram_pkg::sync_word[31:24], 1'b1);
        drive_byte(vram_pkg::sync_word[23:16], 1'b1);
        drive_byte(vram_pkg::sync_word[15:8], 1'b1);
        drive_byte(vram_pkg::sync_word[7:0], 1'b1);
        drive_byte(start[23:16], 1'b1);
        drive_byte(start[15:8], 1'b1);
        drive_byte(start[7:0], 1'b1);
        for (int i = 0; i < n; i++) begin
            drive_byte(data[i], 1'b1);
            model[color][addr] = data[i];
            if (color == vram_pkg::color_blue) begin
                color = 2'd0;
                addr  = next_addr(addr);
            end else begin
                color = color + 2'd1;
            end
        end
        idle(4);
    endtask

    task automatic read_pixel(input vram_pkg::vram_addr_t a, output vram_pkg::pixel_t px,
                              output bit ok);
        ok      = 1'b0;
        px      = '0;
        rd_en   = 1'b1;
        rd_addr = a;
        @(posedge dclk);
        #1;
        rd_en = 1'b0;
        for (int i = 0; i < 20 && !ok; i++) begin
            @(posedge dclk);
            #1;
            if (rd_valid) begin
                ok = 1'b1;
                px = rd_pixel;
            end
        end
        if (!ok) begin
            $display("no read response arrived for address %0d within 20 cycles", a);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input vram_pkg::vram_addr_t a);
        vram_pkg::pixel_t px;
        bit               ok;
        read_pixel(a, px, ok);
        if (ok)
            check_pixel(name, expected_pixel(a), px);
    endtask

    // one read per cycle, responses matched in issue order
    task automatic read_burst(input string name, input vram_pkg::vram_addr_t addrs[$]);
        vram_pkg::vram_addr_t pending[$];
        int                   idx;
        int                   got;
        logic                 exp_valid;
        idx = 0;
        got = 0;
        for (int cyc = 0; cyc < addrs.size() + 20 && got < addrs.size(); cyc++) begin
            rd_en = (idx < addrs.size());
            if (idx < addrs.size()) begin
                rd_addr = addrs[idx];
                pending.push_back(addrs[idx]);
                idx++;
            end
            @(posedge dclk);
            #1;
            // request of one loop pass answers in the next pass
            exp_valid = (cyc >= 1 && cyc <= addrs.size());
            check_valid(name, exp_valid, rd_valid);
            if (rd_valid === 1'b1 && pending.size() > 0) begin
                check_pixel(name, expected_pixel(pending.pop_front()), rd_pixel);
                got++;
            end
        end
        rd_en = 1'b0;
        if (got < addrs.size()) begin
            $display("only %0d of %0d read responses arrived", got, addrs.size());
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_basic_frame();
        vram_pkg::byte_t q[$];
        for (int i = 0; i < 18; i++)
            q.push_back(vram_pkg::byte_t'(i * 17 + 3));
        send_packet(24'd100, q);
        for (int a = 100; a < 106; a++)
            check_addr("basic_frame", vram_pkg::vram_addr_t'(a));
        finish_test("basic_frame");
    endtask

    task automatic test_noise_before_sync();
        vram_pkg::byte_t junk[$];
        vram_pkg::byte_t muted[$];
        vram_pkg::byte_t lead[$];
        vram_pkg::byte_t q[$];
        junk  = {8'h3c, 8'h05, 8'ha8, 8'h7e};
        // full sync aimed at pixel 104, but with en low
        muted = {8'h05, 8'ha8, 8'h00, 8'h00, 8'h00, 8'h00, 8'h68, 8'hde, 8'had, 8'hbe};
        // partial sync right before the real one
        lead  = {8'h99, 8'h05, 8'ha8, 8'h00, 8'h01};
        q     = {8'h41, 8'h42, 8'h43, 8'h51, 8'h52, 8'h53, 8'h61, 8'h62, 8'h63};
        drive_bytes(junk, 1'b1);
        drive_bytes(muted, 1'b0);
        drive_bytes(lead, 1'b1);
        send_packet(24'd200, q);
        for (int a = 200; a < 203; a++)
            check_addr("noise_before_sync", vram_pkg::vram_addr_t'(a));
        // still the basic frame value
        check_addr("noise_before_sync", 16'd104);
        finish_test("noise_before_sync");
    endtask

    task automatic test_wrap_and_clamp();
        vram_pkg::byte_t q[$];
        for (int i = 0; i < 12; i++)
            q.push_back(vram_pkg::byte_t'(i * 29 + 7));
        send_packet(24'(vram_pkg::pix_count - 2), q);
        check_addr("wrap_and_clamp", vram_pkg::vram_addr_t'(vram_pkg::pix_count - 2));
        check_addr("wrap_and_clamp", vram_pkg::vram_addr_t'(vram_pkg::pix_count - 1));
        check_addr("wrap_and_clamp", 16'd0);
        check_addr("wrap_and_clamp", 16'd1);
        q.delete();
        for (int i = 0; i < 6; i++)
            q.push_back(vram_pkg::byte_t'(i * 13 + 200));
        send_packet(24'h0fffff, q);
        check_addr("wrap_and_clamp", 16'd0);
        check_addr("wrap_and_clamp", 16'd1);
        finish_test("wrap_and_clamp");
    endtask

    task automatic test_aborted_pixel();
        vram_pkg::byte_t  q[$];
        vram_pkg::pixel_t px;
        bit               ok;
        q = {8'h10, 8'h20, 8'h30};
        send_packet(24'd300, q);
        // red and green only, then en drops
        q = {8'haa, 8'hbb, 8'hcc};
        send_packet(24'd300, q, 2);
        // no sync, so these must be ignored
        q = {8'h11, 8'h22, 8'h33, 8'h44};
        drive_bytes(q, 1'b1);
        idle(4);
        read_pixel(16'd300, px, ok);
        if (ok) begin
            check_byte("aborted_pixel", 8'haa, px.red);
            check_byte("aborted_pixel", 8'hbb, px.green);
            check_byte("aborted_pixel", 8'h30, px.blue);
        end
        q = {8'h71, 8'h72, 8'h73, 8'h81, 8'h82, 8'h83};
        send_packet(24'd310, q);
        check_addr("aborted_pixel", 16'd310);
        check_addr("aborted_pixel", 16'd311);
        check_addr("aborted_pixel", 16'd300);
        finish_test("aborted_pixel");
    endtask

    task automatic test_random_packets();
        vram_pkg::byte_t      q[$];
        vram_pkg::vram_addr_t addrs[$];
        vram_pkg::vram_addr_t a;
        logic [23:0]          start;
        int                   npix;
        for (int k = 0; k < 8; k++) begin
            q.delete();
            npix = int'($urandom_range(40, 3));
            if (k == 5)
                start = 24'h800000 | 24'($urandom);
            else
                start = 24'($urandom_range(vram_pkg::pix_count - 1, 0));
            for (int i = 0; i < npix * 3; i++)
                q.push_back(vram_pkg::byte_t'($urandom));
            // sync word as pixel data in every other packet
            if (k % 2 == 0) begin
                q[3] = 8'h05;
                q[4] = 8'ha8;
                q[5] = 8'h00;
                q[6] = 8'h00;
            end
            a = first_addr(start);
            for (int p = 0; p < npix; p++) begin
                addrs.push_back(a);
                a = next_addr(a);
            end
            send_packet(start, q);
        end
        read_burst("random_packets", addrs);
        finish_test("random_packets");
    endtask

    initial begin
        void'($urandom(32'hbc011715));
        rst_n        = 1'b0;
        en           = 1'b0;
        data8b       = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (10) @(posedge dclk);
        #1;
        rst_n = 1'b1;
        idle(2);
        test_basic_frame();
        test_noise_before_sync();
        test_wrap_and_clamp();
        test_aborted_pixel();
        test_random_packets();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then search the log for the fail line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_frame_writer -f src.f -o sim \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: src.f
src/vram_pkg.sv
src/plane_if.sv
src/stream_deframer.sv
src/color_plane.sv
src/pixel_reader.sv
src/frame_writer_top.sv
dv/tb_frame_writer.sv

// File: src/color_plane.sv
module color_plane (
    input  logic    dclk,
    plane_if.plane  bus
);

    // one byte per pixel of the frame
    vram_pkg::byte_t mem [vram_pkg::pix_count];

    // local copies of the read request
    logic                 rd_en;
    vram_pkg::vram_addr_t rd_addr;

    assign rd_en   = bus.rd_en;
    assign rd_addr = bus.rd_addr;

    // write port
    // takes effect on the edge where wr_en is high
    always_ff @(posedge dclk) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_data;
        end
    end

    // read port, registered
    // same address write in the same cycle returns the old byte
    always_ff @(posedge dclk) begin
        if (rd_en) begin
            bus.rd_data <= mem[rd_addr];
        end
    end

    // deframer and reader both bound their addresses to the frame
    a_wr_in_frame: assert property (@(posedge dclk)
        bus.wr_en |-> bus.wr_addr < vram_pkg::pix_count);

    a_rd_in_frame: assert property (@(posedge dclk)
        rd_en |-> rd_addr < vram_pkg::pix_count);

endmodule

// File: src/frame_writer_top.sv
module frame_writer_top (
    input  logic                   dclk,
    input  logic                   rst_n,
    input  logic                   en,
    input  vram_pkg::byte_t        data8b,
    input  logic                   rd_en,
    input  vram_pkg::vram_addr_t   rd_addr,
    output logic                   rd_valid,
    output vram_pkg::pixel_t       rd_pixel
);

    // one bus per colour, indexed by color_e
    plane_if planes [vram_pkg::num_planes] ();

    // byte stream in, plane write strobes out
    stream_deframer deframer_i (
        .dclk   (dclk),
        .rst_n  (rst_n),
        .en     (en),
        .data8b (data8b),
        .planes (planes)
    );

    // red, green, blue memories
    for (genvar p = 0; p < vram_pkg::num_planes; p++) begin : g_plane
        color_plane plane_i (
            .dclk (dclk),
            .bus  (planes[p])
        );
    end

    // read port for the outside
    pixel_reader reader_i (
        .dclk     (dclk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .planes   (planes),
        .rd_valid (rd_valid),
        .rd_pixel (rd_pixel)
    );

endmodule

// File: src/pixel_reader.sv
module pixel_reader (
    input  logic                   dclk,
    input  logic                   rst_n,
    input  logic                   rd_en,
    input  vram_pkg::vram_addr_t   rd_addr,
    plane_if.reader                planes [vram_pkg::num_planes],
    output logic                   rd_valid,
    output vram_pkg::pixel_t       rd_pixel
);

    // plane data valid in this cycle
    logic            rd_en_q;
    // returned bytes, indexed by colour
    vram_pkg::byte_t ret_bytes [vram_pkg::num_planes];

    // every request goes to all three planes at once
    for (genvar p = 0; p < vram_pkg::num_planes; p++) begin : g_rd
        assign planes[p].rd_en   = rd_en;
        assign planes[p].rd_addr = rd_addr;
        assign ret_bytes[p]      = planes[p].rd_data;
    end

    // two stage valid pipe
    // stage one follows the plane read latency
    always_ff @(posedge dclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_q  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_en_q  <= rd_en;
            rd_valid <= rd_en_q;
        end
    end

    // pack rgb into one pixel, no reset on payload
    always_ff @(posedge dclk) begin
        if (rd_en_q) begin
            rd_pixel.red   <= ret_bytes[vram_pkg::color_red];
            rd_pixel.green <= ret_bytes[vram_pkg::color_green];
            rd_pixel.blue  <= ret_bytes[vram_pkg::color_blue];
        end
    end

    // fixed two cycle latency through plane and output register
    a_rd_latency: assert property (@(posedge dclk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2));

endmodule

// File: src/plane_if.sv
interface plane_if;

    // write side, one strobe per byte
    logic                   wr_en;
    vram_pkg::vram_addr_t   wr_addr;
    vram_pkg::byte_t        wr_data;

    // read side, data one cycle after rd_en
    logic                   rd_en;
    vram_pkg::vram_addr_t   rd_addr;
    vram_pkg::byte_t        rd_data;

    // stream deframer side
    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    // pixel reader side
    modport reader (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    // the memory itself
    modport plane (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: src/stream_deframer.sv
module stream_deframer (
    input  logic            dclk,
    input  logic            rst_n,
    input  logic            en,
    input  vram_pkg::byte_t data8b,
    plane_if.writer         planes [vram_pkg::num_planes]
);

    // hunt also takes the high address byte
    typedef enum logic [1:0] {
        st_hunt,
        st_addr_mid,
        st_addr_lo,
        st_data
    } state_t;

    logic                           en_q;
    vram_pkg::byte_t                data_q;
    logic [31:0]                    window;
    state_t                         state;
    vram_pkg::color_e               color;
    vram_pkg::vram_addr_t           pix_addr;
    vram_pkg::byte_t                addr_hi;
    vram_pkg::byte_t                addr_mid;
    logic [23:0]                    start_addr;
    logic [vram_pkg::num_planes-1:0] wr_en_q;
    vram_pkg::vram_addr_t           wr_addr_q;
    vram_pkg::byte_t                wr_data_q;

    // full 24 bit start address while the low byte sits in data_q
    assign start_addr = {addr_hi, addr_mid, data_q};

    // input register, payload byte
    always_ff @(posedge dclk) begin
        data_q <= data8b;
        // last hunt byte before the switch is the high address byte
        if (en_q && state == st_hunt) addr_hi <= data_q;
        if (en_q && state == st_addr_mid) addr_mid <= data_q;
        wr_addr_q <= pix_addr;
        wr_data_q <= data_q;
    end

    always_ff @(posedge dclk or negedge rst_n) begin
        if (!rst_n) begin
            en_q     <= 1'b0;
            window   <= '0;
            state    <= st_hunt;
            color    <= vram_pkg::color_red;
            pix_addr <= '0;
            wr_en_q  <= '0;
        end else begin
            en_q    <= en;
            wr_en_q <= '0;
            if (!en_q) begin
                // gap in the stream, sync must start over
                window <= '0;
                state  <= st_hunt;
                color  <= vram_pkg::color_red;
            end else begin
                window <= {window[23:0], data_q};
                case (state)
                    st_hunt: begin
                        // previous four qualified bytes were the sync word
                        if (window == vram_pkg::sync_word) state <= st_addr_mid;
                    end
                    st_addr_mid: begin
                        state <= st_addr_lo;
                    end
                    st_addr_lo: begin
                        // out of range start goes to pixel 0
                        if (start_addr < vram_pkg::pix_count)
                            pix_addr <= start_addr[vram_pkg::addr_w-1:0];
                        else
                            pix_addr <= '0;
                        color <= vram_pkg::color_red;
                        state <= st_data;
                    end
                    default: begin
                        // one plane per byte, in rgb order
                        wr_en_q[color] <= 1'b1;
                        case (color)
                            vram_pkg::color_red:   color <= vram_pkg::color_green;
                            vram_pkg::color_green: color <= vram_pkg::color_blue;
                            default: begin
                                color <= vram_pkg::color_red;
                                // next pixel after blue, wrap at end of frame
                                if (pix_addr == vram_pkg::vram_addr_t'(vram_pkg::pix_count - 1))
                                    pix_addr <= '0;
                                else
                                    pix_addr <= pix_addr + 1'b1;
                            end
                        endcase
                    end
                endcase
            end
        end
    end

    // same address and byte go to every plane, only the strobe differs
    for (genvar p = 0; p < vram_pkg::num_planes; p++) begin : g_wr
        assign planes[p].wr_en   = wr_en_q[p];
        assign planes[p].wr_addr = wr_addr_q;
        assign planes[p].wr_data = wr_data_q;
    end

    // one byte in, at most one plane written
    a_one_write: assert property (@(posedge dclk) disable iff (!rst_n)
        $onehot0(wr_en_q));

    // clamp and wrap keep every write inside the frame
    a_wr_range: assert property (@(posedge dclk) disable iff (!rst_n)
        |wr_en_q |-> wr_addr_q < vram_pkg::pix_count);

endmodule

// File: src/vram_pkg.sv
package vram_pkg;

    // 240 x 240 panel, one byte per colour per pixel
    localparam int pix_count = 57600;

    // wide enough for pix_count - 1
    localparam int addr_w = 16;

    // red, green, blue
    localparam int num_planes = 3;

    // frame start marker on the byte stream
    localparam logic [31:0] sync_word = 32'h05a80000;

    // address into one colour plane
    typedef logic [addr_w-1:0] vram_addr_t;

    // one stream byte, also one plane entry
    typedef logic [7:0] byte_t;

    // red high, green middle, blue low
    typedef struct packed {
        byte_t red;
        byte_t green;
        byte_t blue;
    } pixel_t;

    // plane index and order of bytes within a pixel on the stream
    typedef enum logic [1:0] {
        color_red   = 2'd0,
        color_green = 2'd1,
        color_blue  = 2'd2
    } color_e;

endpackage
